// ==== Bender.yml ====
package:
  name: deep_gate

sources:
  - target: rtl
    include_dirs:
      - .
    files:
      - mlp_pkg.sv
      - uart_rx.sv
      - frame_buffer.sv
      - mlp_tile.sv
      - result_uart_tx.sv
      - deep_gate_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_deep_gate.sv

// ==== deep_gate_top.sv ====
`default_nettype none

module deep_gate_top (
	input  wire       clk,
	input  wire       reset,
	input  wire       rx,
	output wire       tx,
	output reg  [7:0] led
);

	logic [7:0]            rx_byte;
	logic                  rx_valid;
	logic                  busy;
	logic                  pix_req;
	logic                  pix_ack;
	mlp_pkg::pixel_beat_t  pix_beat;
	logic                  res_req;
	logic                  res_ack;
	mlp_pkg::result_beat_t res_beat;

	uart_rx u_rx (
		.clk      (clk),
		.reset    (reset),
		.rx       (rx),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid)
	);

	frame_buffer u_frame (
		.clk      (clk),
		.reset    (reset),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid),
		.busy     (busy),
		.pix_req  (pix_req),
		.pix_beat (pix_beat),
		.pix_ack  (pix_ack)
	);

	mlp_tile u_tile (
		.clk      (clk),
		.reset    (reset),
		.pix_req  (pix_req),
		.pix_beat (pix_beat),
		.pix_ack  (pix_ack),
		.busy     (busy),
		.res_req  (res_req),
		.res_beat (res_beat),
		.res_ack  (res_ack)
	);

	result_uart_tx u_tx (
		.clk      (clk),
		.reset    (reset),
		.res_req  (res_req),
		.res_beat (res_beat),
		.res_ack  (res_ack),
		.tx       (tx)
	);

	// leds follow every received byte, dropped ones included
	always_ff @(posedge clk) begin
		if (reset)
			led <= '0;
		else if (rx_valid)
			led <= rx_byte;
	end

endmodule

`default_nettype wire

// ==== frame_buffer.sv ====
`default_nettype none

`include "mlp_macros.svh"

module frame_buffer (
	input  wire                      clk,
	input  wire                      reset,
	input  wire  [7:0]               rx_byte,
	input  wire                      rx_valid,
	input  wire                      busy,
	output reg                       pix_req,
	output mlp_pkg::pixel_beat_t     pix_beat,
	input  wire                      pix_ack
);

	typedef enum logic [1:0] {S_IDLE, S_READ, S_REQ, S_WAIT} state_t;

	logic [7:0] mem [0:`IMG_PIXELS-1];

	state_t     state;
	logic [9:0] wr_ptr;
	logic [9:0] rd_ptr;
	logic       full;
	logic [1:0] match_cnt; // start bytes seen in a row
	logic       take;

	// bytes are dropped while a frame is in flight
	assign take = rx_valid && (state == S_IDLE) && !busy;

	always_ff @(posedge clk) begin
		if (take && !full)
			mem[wr_ptr] <= rx_byte;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr    <= '0;
			full      <= 1'b0;
			match_cnt <= '0;
		end else if (take) begin
			if (!full) begin
				wr_ptr <= wr_ptr + 1'b1;
				if (wr_ptr == 10'(`IMG_PIXELS - 1))
					full <= 1'b1;
			end else if (rx_byte == `CMD_CLEAR) begin
				wr_ptr    <= '0; // reload from pixel 0
				full      <= 1'b0;
				match_cnt <= '0;
			end else if (rx_byte == `CMD_START) begin
				match_cnt <= (match_cnt == 2'd2) ? 2'd0 : match_cnt + 1'b1;
			end else
				match_cnt <= '0;
		end
	end

	// streaming side, one beat per four-phase handshake
	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= S_IDLE;
			rd_ptr  <= '0;
			pix_req <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (take && full && rx_byte == `CMD_START && match_cnt == 2'd2) begin
						rd_ptr <= '0;
						state  <= S_READ;
					end
				end
				S_READ: begin
					pix_beat.pixel <= mem[rd_ptr];
					pix_beat.idx   <= rd_ptr;
					pix_beat.last  <= (rd_ptr == 10'(`IMG_PIXELS - 1));
					state          <= S_REQ;
				end
				S_REQ: begin
					if (pix_ack) begin
						pix_req <= 1'b0;
						state   <= S_WAIT;
					end else
						pix_req <= 1'b1; // beat already stable
				end
				default: begin
					if (!pix_ack) begin
						if (pix_beat.last)
							state <= S_IDLE;
						else begin
							rd_ptr <= rd_ptr + 1'b1;
							state  <= S_READ;
						end
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
mlp_pkg.sv
uart_rx.sv
frame_buffer.sv
mlp_tile.sv
result_uart_tx.sv
deep_gate_top.sv
tb_clock_gen.sv
tb_deep_gate.sv

// ==== mlp_macros.svh ====
`ifndef MLP_MACROS_SVH
`define MLP_MACROS_SVH

// frame geometry, 28 x 28 greyscale
`define IMG_PIXELS 784

`define CLKS_PER_BIT 8 // uart oversampling ratio
`define N_OUT 10 // output neurons

// weight rule: w(n, i) = low byte of (i * W_MUL + n * W_ADD), signed
`define W_MUL 37
`define W_ADD 101
`define ACC_SHIFT 12

`define CMD_START 8'h26 // '&'
`define CMD_CLEAR 8'h24 // '$'

`endif

// ==== mlp_pkg.sv ====
`default_nettype none

package mlp_pkg;

	// one pixel on its way from the frame buffer to the tile
	typedef struct packed {
		logic [7:0] pixel; // greyscale value, unsigned
		logic [9:0] idx;   // position in the frame, 0 .. 783
		logic       last;  // final pixel of the frame
	} pixel_beat_t;

	// one reply byte, scores first, argmax index last
	typedef struct packed {
		logic [7:0] data;
		logic       last; // set on the class index
	} result_beat_t;

endpackage

`default_nettype wire

// ==== mlp_tile.sv ====
`default_nettype none

`include "mlp_macros.svh"

module mlp_tile (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      pix_req,
	input  mlp_pkg::pixel_beat_t     pix_beat,
	output reg                       pix_ack,
	output reg                       busy,
	output reg                       res_req,
	output mlp_pkg::result_beat_t    res_beat,
	input  wire                      res_ack
);

	typedef enum logic [2:0] {T_IDLE, T_ACK, T_SCORE, T_SEND, T_SWAIT} state_t;

	state_t             state;
	logic signed [31:0] acc [0:`N_OUT-1];
	logic        [7:0]  score [0:`N_OUT-1];
	logic signed [31:0] best_val;
	logic        [3:0]  best_idx;
	logic        [3:0]  cnt; // score scan position, then reply position
	logic               last_seen;

	// rule weight, no memory behind it
	function automatic logic signed [7:0] weight(input logic [9:0] idx, input int n);
		int raw;
		raw = int'(idx) * `W_MUL + n * `W_ADD;
		return raw[7:0];
	endfunction

	function automatic logic [7:0] clip(input logic signed [31:0] a);
		logic signed [31:0] s;
		s = a >>> `ACC_SHIFT;
		if (a < 0)
			return 8'd0;
		else if (s > 32'sd255)
			return 8'd255;
		else
			return s[7:0];
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= T_IDLE;
			pix_ack   <= 1'b0;
			res_req   <= 1'b0;
			busy      <= 1'b0;
			cnt       <= '0;
			last_seen <= 1'b0;
			for (int n = 0; n < `N_OUT; n++)
				acc[n] <= '0;
		end else begin
			case (state)
				T_IDLE: begin
					if (pix_req && !pix_ack) begin
						for (int n = 0; n < `N_OUT; n++)
							acc[n] <= acc[n] + $signed({1'b0, pix_beat.pixel})
								* weight(pix_beat.idx, n);
						last_seen <= pix_beat.last;
						pix_ack   <= 1'b1;
						busy      <= 1'b1;
						state     <= T_ACK;
					end
				end
				T_ACK: begin
					if (!pix_req) begin
						pix_ack <= 1'b0;
						cnt     <= '0;
						state   <= last_seen ? T_SCORE : T_IDLE;
					end
				end
				T_SCORE: begin
					if (cnt < 4'(`N_OUT)) begin
						score[cnt] <= clip(acc[cnt]);
						// strict compare keeps the lowest index on a tie
						if (cnt == 4'd0 || acc[cnt] > best_val) begin
							best_val <= acc[cnt];
							best_idx <= cnt;
						end
						cnt <= cnt + 1'b1;
					end else begin
						res_beat.data <= score[0];
						res_beat.last <= 1'b0;
						res_req       <= 1'b1;
						cnt           <= '0;
						state         <= T_SEND;
					end
				end
				T_SEND: begin
					if (res_ack) begin
						res_req <= 1'b0;
						if (res_beat.last) begin // index taken, frame done
							busy <= 1'b0;
							for (int n = 0; n < `N_OUT; n++)
								acc[n] <= '0;
						end
						state <= T_SWAIT;
					end
				end
				default: begin
					if (!res_ack) begin
						if (res_beat.last)
							state <= T_IDLE;
						else begin
							cnt <= cnt + 1'b1;
							if (cnt + 1'b1 < 4'(`N_OUT)) begin
								res_beat.data <= score[cnt + 1'b1];
								res_beat.last <= 1'b0;
							end else begin
								res_beat.data <= {4'd0, best_idx}; // argmax
								res_beat.last <= 1'b1;
							end
							res_req <= 1'b1;
							state   <= T_SEND;
						end
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== result_uart_tx.sv ====
`default_nettype none

`include "mlp_macros.svh"

module result_uart_tx (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      res_req,
	input  mlp_pkg::result_beat_t    res_beat,
	output reg                       res_ack,
	output reg                       tx
);

	localparam int CW = $clog2(`CLKS_PER_BIT);

	logic          active; // a byte is on the line
	logic [8:0]    shreg;  // data bits then stop bit
	logic [3:0]    bit_cnt;
	logic [CW-1:0] clk_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			tx      <= 1'b1;
			res_ack <= 1'b0;
			active  <= 1'b0;
			bit_cnt <= '0;
			clk_cnt <= '0;
		end else begin
			// ack side of the handshake
			if (res_ack && !res_req)
				res_ack <= 1'b0;

			if (!active) begin
				if (res_req && !res_ack) begin
					shreg   <= {1'b1, res_beat.data};
					tx      <= 1'b0; // start bit
					active  <= 1'b1;
					bit_cnt <= '0;
					clk_cnt <= '0;
					res_ack <= 1'b1;
				end
			end else if (clk_cnt == CW'(`CLKS_PER_BIT - 1)) begin
				clk_cnt <= '0;
				if (bit_cnt == 4'd9) begin
					active <= 1'b0; // stop bit finished
					tx     <= 1'b1;
				end else begin
					tx      <= shreg[0];
					shreg   <= {1'b1, shreg[8:1]};
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else
				clk_cnt <= clk_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
	output logic clk
);

	initial clk = 1'b0;

	always #5 clk = ~clk; // period 10

endmodule

`default_nettype wire

// ==== tb_deep_gate.sv ====
`default_nettype none

`include "mlp_macros.svh"

module tb_deep_gate;

	localparam int REPLY_TIMEOUT = 20000; // cycles per wait and well above one inference
	localparam int N_REPLY = `N_OUT + 1;
	localparam int N_ROWS = 13;

	localparam logic [1:0] OP_FRAME = 2'd0;
	localparam logic [1:0] OP_CMD   = 2'd1;
	localparam logic [1:0] OP_CLEAR = 2'd2;

	localparam logic [1:0] FILL_RANDOM = 2'd0;
	localparam logic [1:0] FILL_CONST  = 2'd1;
	localparam logic [1:0] FILL_RAMP   = 2'd2;
	localparam logic [1:0] FILL_ZERO   = 2'd3;

	localparam logic [47:0] START3 = {`CMD_START, `CMD_START, `CMD_START, 24'h0};

	typedef struct packed {
		logic [1:0]  op;
		logic [1:0]  fill;
		logic [7:0]  value;
		logic [47:0] cmds;    // first command byte in the top byte
		logic [2:0]  n_cmds;
		logic        noise;   // start bytes sent while the reply runs
		logic [3:0]  n_reply; // 11 or 0
	} row_t;

	wire        clk;
	wire        tx;
	wire  [7:0] led;
	logic       reset;
	logic       rx;

	row_t       rows [0:N_ROWS-1];
	logic [7:0] frame [0:`IMG_PIXELS-1];
	logic [7:0] reply_q [$];
	logic [7:0] model_q [$];
	integer     seed;
	int         err_count;
	int         fail_tests;

	tb_clock_gen clock (
		.clk (clk)
	);

	deep_gate_top uut (
		.clk   (clk),
		.reset (reset),
		.rx    (rx),
		.tx    (tx),
		.led   (led)
	);

	// led should settle on the byte shortly after its stop bit
	task automatic check_led(input logic [7:0] b);
		int waited;
		waited = 0;
		@(negedge clk);
		while (led !== b && waited < 4 * `CLKS_PER_BIT) begin
			@(negedge clk);
			waited++;
		end
		if (led !== b) begin
			$display("FAIL t=%0t led is %02h after sending %02h", $time, led, b);
			err_count++;
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		logic [9:0] bits;
		int k;
		bits = {1'b1, b, 1'b0}; // start bit sent first and data lsb first
		for (k = 0; k < 10; k++) begin
			@(posedge clk);
			rx <= bits[k];
			repeat (`CLKS_PER_BIT - 1) @(posedge clk);
		end
		@(posedge clk);
		check_led(b);
	endtask

	task automatic receive_byte(output logic [7:0] b, output logic got);
		int waited;
		int k;
		b = 8'h00;
		got = 1'b0;
		waited = 0;
		@(negedge clk);
		while (tx !== 1'b0 && waited < REPLY_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (tx === 1'b0) begin
			repeat (`CLKS_PER_BIT / 2) @(negedge clk); // middle of start bit
			for (k = 0; k < 8; k++) begin
				repeat (`CLKS_PER_BIT) @(negedge clk);
				b[k] = tx;
			end
			repeat (`CLKS_PER_BIT) @(negedge clk);
			if (tx !== 1'b1) begin
				$display("FAIL t=%0t stop bit of a reply byte was low", $time);
				err_count++;
			end
			got = 1'b1;
		end
	endtask

	task automatic collect_reply(input int expected);
		logic [7:0] b;
		logic got;
		got = 1'b1;
		while (got && reply_q.size() < 2 * N_REPLY) begin
			receive_byte(b, got);
			if (got)
				reply_q.push_back(b);
		end
		if (reply_q.size() < expected) begin
			$display("timed out waiting for reply byte %0d", reply_q.size() + 1);
			err_count++;
		end
	endtask

	// three start bytes in the middle of a reply that should all be dropped
	task automatic send_during_reply();
		int waited;
		int k;
		waited = 0;
		while (reply_q.size() == 0 && waited < REPLY_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (reply_q.size() != 0)
			for (k = 0; k < 3; k++)
				send_byte(`CMD_START);
	endtask

	task automatic build_frame(input logic [1:0] fill, input logic [7:0] value);
		int i;
		for (i = 0; i < `IMG_PIXELS; i++) begin
			case (fill)
				FILL_RANDOM: frame[i] = 8'($random(seed));
				FILL_CONST:  frame[i] = value;
				FILL_RAMP:   frame[i] = 8'(i);
				default:     frame[i] = 8'h00;
			endcase
		end
	endtask

	function automatic logic [7:0] clip_score(input int a);
		int s;
		if (a < 0)
			return 8'd0;
		s = a / (1 << `ACC_SHIFT);
		if (s > 255)
			return 8'd255; // saturate
		return 8'(s);
	endfunction

	// reference model over the frame that was sent
	task automatic compute_model();
		int acc [0:`N_OUT-1];
		int n;
		int i;
		int w;
		int best;
		model_q.delete();
		for (n = 0; n < `N_OUT; n++) begin
			acc[n] = 0;
			for (i = 0; i < `IMG_PIXELS; i++) begin
				w = (i * `W_MUL + n * `W_ADD) % 256;
				if (w > 127)
					w = w - 256; // signed byte
				acc[n] = acc[n] + int'(frame[i]) * w;
			end
		end
		best = 0;
		for (n = 1; n < `N_OUT; n++)
			if (acc[n] > acc[best])
				best = n; // ties keep the lower index
		for (n = 0; n < `N_OUT; n++)
			model_q.push_back(clip_score(acc[n]));
		model_q.push_back(8'(best));
	endtask

	task automatic check_reply(input int expected);
		int k;
		if (reply_q.size() != expected) begin
			$display("FAIL t=%0t reply has %0d bytes, expected %0d",
				$time, reply_q.size(), expected);
			err_count++;
		end else if (expected == N_REPLY) begin
			compute_model();
			for (k = 0; k < N_REPLY; k++) begin
				if (reply_q[k] !== model_q[k]) begin
					$display("FAIL t=%0t reply byte %0d is %02h, expected %02h",
						$time, k, reply_q[k], model_q[k]);
					err_count++;
				end
			end
		end
	endtask

	function automatic string op_name(input logic [1:0] op);
		case (op)
			OP_FRAME: return "frame";
			OP_CLEAR: return "clear";
			default:  return "command";
		endcase
	endfunction

	initial begin
		int t;
		int k;
		int errs_before;
		row_t r;
		reset = 1'b1;
		rx = 1'b1; // line idle
		seed = 32'h1911;
		err_count = 0;
		fail_tests = 0;

		rows[0]  = {OP_FRAME, FILL_RANDOM, 8'h00, 48'h0, 3'd0, 1'b0, 4'd0};
		rows[1]  = {OP_CMD, FILL_ZERO, 8'h00, START3, 3'd3, 1'b1, 4'd11};
		rows[2]  = {OP_CLEAR, FILL_ZERO, 8'h00, 48'h0, 3'd0, 1'b0, 4'd0};
		rows[3]  = {OP_FRAME, FILL_ZERO, 8'h00, 48'h0, 3'd0, 1'b0, 4'd0};
		rows[4]  = {OP_CMD, FILL_ZERO, 8'h00, START3, 3'd3, 1'b0, 4'd11};
		rows[5]  = {OP_CLEAR, FILL_ZERO, 8'h00, 48'h0, 3'd0, 1'b0, 4'd0};
		rows[6]  = {OP_FRAME, FILL_CONST, 8'hff, 48'h0, 3'd0, 1'b0, 4'd0};
		rows[7]  = {OP_CMD, FILL_ZERO, 8'h00, START3, 3'd3, 1'b0, 4'd11};
		rows[8]  = {OP_CMD, FILL_ZERO, 8'h00,
			{`CMD_START, `CMD_START, 8'h55, `CMD_START, `CMD_START, `CMD_START},
			3'd6, 1'b0, 4'd11};
		// two more start bytes after the broken match would launch if it survived
		rows[9]  = {OP_CMD, FILL_ZERO, 8'h00,
			{`CMD_START, 8'h55, `CMD_START, `CMD_START, 8'h55, 8'h00},
			3'd5, 1'b0, 4'd0};
		rows[10] = {OP_CLEAR, FILL_ZERO, 8'h00, 48'h0, 3'd0, 1'b0, 4'd0};
		rows[11] = {OP_FRAME, FILL_RAMP, 8'h00, 48'h0, 3'd0, 1'b0, 4'd0};
		rows[12] = {OP_CMD, FILL_ZERO, 8'h00, START3, 3'd3, 1'b0, 4'd11};

		repeat (10) @(posedge clk);
		reset <= 1'b0;
		repeat (2) @(posedge clk);

		for (t = 0; t < N_ROWS; t++) begin
			r = rows[t];
			errs_before = err_count;
			case (r.op)
				OP_FRAME: begin
					build_frame(r.fill, r.value);
					for (k = 0; k < `IMG_PIXELS; k++)
						send_byte(frame[k]);
				end
				OP_CLEAR: send_byte(`CMD_CLEAR);
				default: begin
					reply_q.delete();
					for (k = 0; k < r.n_cmds; k++)
						send_byte(r.cmds[47 - 8 * k -: 8]);
					fork
						collect_reply(r.n_reply);
						if (r.noise)
							send_during_reply();
					join
					check_reply(r.n_reply);
				end
			endcase
			if (err_count == errs_before)
				$display("test %0d (%s) ok", t, op_name(r.op));
			else begin
				$display("test %0d (%s) failed with %0d errors",
					t, op_name(r.op), err_count - errs_before);
				fail_tests++;
			end
		end

		$display("tests run %0d, failed %0d, errors %0d", N_ROWS, fail_tests, err_count);
		if (err_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
`default_nettype none

`include "mlp_macros.svh"

module uart_rx (
	input  wire       clk,
	input  wire       reset,
	input  wire       rx,
	output reg  [7:0] rx_byte,
	output reg        rx_valid
);

	localparam int CW = $clog2(`CLKS_PER_BIT);
	localparam int HALF = `CLKS_PER_BIT / 2;

	typedef enum logic [1:0] {U_IDLE, U_START, U_DATA, U_STOP} state_t;

	state_t          state;
	logic            rx_meta;
	logic            rx_sync;
	logic [CW-1:0]   clk_cnt;
	logic [2:0]      bit_cnt;
	logic [7:0]      shreg;

	always_ff @(posedge clk) begin
		if (reset) begin
			rx_meta  <= 1'b1; // line idles high
			rx_sync  <= 1'b1;
			state    <= U_IDLE;
			clk_cnt  <= '0;
			bit_cnt  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_meta  <= rx;
			rx_sync  <= rx_meta;
			rx_valid <= 1'b0;
			case (state)
				U_IDLE: begin
					clk_cnt <= '0;
					if (!rx_sync)
						state <= U_START; // falling edge, start bit
				end
				U_START: begin
					if (clk_cnt == CW'(HALF - 1)) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						// glitch shorter than half a bit goes back to idle
						state   <= rx_sync ? U_IDLE : U_DATA;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				U_DATA: begin
					if (clk_cnt == CW'(`CLKS_PER_BIT - 1)) begin
						clk_cnt <= '0;
						shreg   <= {rx_sync, shreg[7:1]}; // lsb first
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= U_STOP;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				default: begin
					if (clk_cnt == CW'(`CLKS_PER_BIT - 1)) begin
						clk_cnt <= '0;
						state   <= U_IDLE;
						if (rx_sync) begin // framing error drops the byte
							rx_byte  <= shreg;
							rx_valid <= 1'b1;
						end
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
			endcase
		end
	end

endmodule

`default_nettype wire
